/* hdl/uart_pkg.sv */
`default_nettype none

package uart_pkg;

  // Bits per character, LSB first on the line
  parameter int DATA_BITS = 8;

  // Register map, byte addresses on a 4-bit bus
  typedef enum logic [3:0] {
    ADDR_CTRL   = 4'h0,  // Baud divisor
    ADDR_STATUS = 4'h4,  // {frame_err, overrun, rx_valid, tx_busy}
    ADDR_TXDATA = 4'h8,
    ADDR_RXDATA = 4'hC
  } reg_addr_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

endpackage

`default_nettype wire

/* hdl/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
  parameter int DIV_WIDTH = 16
) (
  input  logic                 sys_clk,
  input  logic                 sys_rst_n,
  input  logic                 rx,
  input  logic [DIV_WIDTH-1:0] divisor,
  output logic [7:0]           rx_byte,
  output logic                 rx_done,
  output logic                 frame_err
);

  localparam int BIT_W = $clog2(uart_pkg::DATA_BITS);

  uart_pkg::rx_state_e  state;
  logic                 rx_meta;
  logic                 rx_sync;
  logic                 rx_prev;   // Delayed copy for edge detection
  logic                 start_edge;
  logic [DIV_WIDTH-1:0] baud_cnt;
  logic [BIT_W-1:0]     bit_cnt;
  logic                 baud_end;
  logic                 half_end;
  logic [7:0]           shift;

  // Two-flop synchronizer plus one more stage for the edge, idles high
  always_ff @(posedge sys_clk) begin
    if (!sys_rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign start_edge = rx_prev & ~rx_sync;
  assign baud_end   = (baud_cnt == divisor - 1'b1);
  // Middle of the start bit, later samples land a full bit apart
  assign half_end   = (baud_cnt == (divisor >> 1) - 1'b1);

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_n) begin
      state    <= uart_pkg::RX_IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      rx_done  <= 1'b0;
    end else begin
      rx_done <= 1'b0;
      case (state)
        uart_pkg::RX_IDLE: begin
          baud_cnt <= '0;
          if (start_edge) state <= uart_pkg::RX_START;
        end
        uart_pkg::RX_START: begin
          if (half_end) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            // Glitch on the line if the start bit is already high again
            state    <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        uart_pkg::RX_DATA: begin
          if (baud_end) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == BIT_W'(uart_pkg::DATA_BITS - 1)) state <= uart_pkg::RX_STOP;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        uart_pkg::RX_STOP: begin
          if (baud_end) begin
            baud_cnt <= '0;
            rx_done  <= 1'b1;  // Byte and frame_err valid next cycle
            state    <= uart_pkg::RX_IDLE;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: state <= uart_pkg::RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (state == uart_pkg::RX_DATA && baud_end) begin
      shift <= {rx_sync, shift[7:1]};  // LSB arrives first
    end
    if (state == uart_pkg::RX_STOP && baud_end) begin
      rx_byte   <= shift;
      frame_err <= ~rx_sync;           // Stop bit must be high
    end
  end

endmodule

`default_nettype wire

/* hdl/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
  parameter int DIV_WIDTH = 16
) (
  input  logic                 sys_clk,
  input  logic                 sys_rst_n,
  input  logic [DIV_WIDTH-1:0] divisor,
  input  logic [7:0]           tx_data,
  input  logic                 tx_start,
  output logic                 tx,
  output logic                 tx_busy
);

  localparam int BIT_W = $clog2(uart_pkg::DATA_BITS);

  uart_pkg::tx_state_e  state;
  logic [DIV_WIDTH-1:0] baud_cnt;
  logic [BIT_W-1:0]     bit_cnt;
  logic                 baud_end;
  logic                 load;
  logic [7:0]           shift;

  assign baud_end = (baud_cnt == divisor - 1'b1);
  assign load     = tx_start && (state == uart_pkg::TX_IDLE);

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_n) begin
      state    <= uart_pkg::TX_IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx       <= 1'b1;
      tx_busy  <= 1'b0;
    end else begin
      if (state == uart_pkg::TX_IDLE || baud_end) baud_cnt <= '0;
      else baud_cnt <= baud_cnt + 1'b1;

      case (state)
        uart_pkg::TX_IDLE: begin
          if (load) begin
            state   <= uart_pkg::TX_START;
            tx      <= 1'b0;       // Start bit
            tx_busy <= 1'b1;
          end
        end
        uart_pkg::TX_START: begin
          if (baud_end) begin
            state   <= uart_pkg::TX_DATA;
            bit_cnt <= '0;
            tx      <= shift[0];
          end
        end
        uart_pkg::TX_DATA: begin
          if (baud_end) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == BIT_W'(uart_pkg::DATA_BITS - 1)) begin
              state <= uart_pkg::TX_STOP;
              tx    <= 1'b1;
            end else begin
              tx    <= shift[1];   // Next bit, shift moves on this edge
            end
          end
        end
        uart_pkg::TX_STOP: begin
          if (baud_end) begin
            state   <= uart_pkg::TX_IDLE;
            tx_busy <= 1'b0;
          end
        end
        default: state <= uart_pkg::TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (load) shift <= tx_data;
    else if (state == uart_pkg::TX_DATA && baud_end) shift <= shift >> 1;
  end

endmodule

`default_nettype wire

/* hdl/uart_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_regs #(
  parameter int DIV_WIDTH     = 16,
  parameter int RESET_DIVISOR = 16
) (
  input  logic                 sys_clk,
  input  logic                 sys_rst_n,
  // AXI4-Lite slave
  input  logic [3:0]           awaddr,
  input  logic                 awvalid,
  output logic                 awready,
  input  logic [31:0]          wdata,
  input  logic                 wvalid,
  output logic                 wready,
  output uart_pkg::axi_resp_e  bresp,
  output logic                 bvalid,
  input  logic                 bready,
  input  logic [3:0]           araddr,
  input  logic                 arvalid,
  output logic                 arready,
  output logic [31:0]          rdata,
  output uart_pkg::axi_resp_e  rresp,
  output logic                 rvalid,
  input  logic                 rready,
  // Engine control
  output logic [DIV_WIDTH-1:0] divisor,
  output logic [7:0]           tx_data,
  output logic                 tx_start,
  input  logic                 tx_busy,
  input  logic [7:0]           rx_byte,
  input  logic                 rx_done,
  input  logic                 frame_err
);

  uart_pkg::reg_addr_e  wr_addr;
  uart_pkg::reg_addr_e  rd_addr;
  uart_pkg::axi_resp_e  wr_resp;
  uart_pkg::axi_resp_e  rd_resp;
  logic [31:0]          rd_data;
  logic                 wr_hs;
  logic                 rd_hs;
  logic                 wr_ctrl;
  logic                 wr_txdata;
  logic                 tx_go;
  logic                 rd_status;
  logic                 rd_rxdata;
  logic [DIV_WIDTH-1:0] wdata_div;
  logic [7:0]           rx_data;
  logic                 rx_valid;
  logic                 rx_overrun;
  logic                 rx_frame_err;

  assign wr_addr = uart_pkg::reg_addr_e'(awaddr);
  assign rd_addr = uart_pkg::reg_addr_e'(araddr);

  // awready and wready always rise together
  assign wr_hs     = awready && awvalid && wvalid;
  assign rd_hs     = arready && arvalid;
  assign wr_ctrl   = wr_hs && (wr_addr == uart_pkg::ADDR_CTRL);
  assign wr_txdata = wr_hs && (wr_addr == uart_pkg::ADDR_TXDATA);
  assign tx_go     = wr_txdata && !tx_busy && !tx_start;  // Busy writes are dropped
  assign rd_status = rd_hs && (rd_addr == uart_pkg::ADDR_STATUS);
  assign rd_rxdata = rd_hs && (rd_addr == uart_pkg::ADDR_RXDATA);
  assign wdata_div = wdata[DIV_WIDTH-1:0];

  always_comb begin
    case (wr_addr)
      uart_pkg::ADDR_CTRL,
      uart_pkg::ADDR_TXDATA: wr_resp = uart_pkg::RESP_OKAY;
      default:               wr_resp = uart_pkg::RESP_SLVERR;
    endcase
  end

  always_comb begin
    rd_data = '0;
    rd_resp = uart_pkg::RESP_OKAY;
    case (rd_addr)
      uart_pkg::ADDR_CTRL:   rd_data = 32'(divisor);
      uart_pkg::ADDR_STATUS: rd_data = {28'd0, rx_frame_err, rx_overrun, rx_valid, tx_busy};
      uart_pkg::ADDR_RXDATA: rd_data = {24'd0, rx_data};
      default:               rd_resp = uart_pkg::RESP_SLVERR;  // TXDATA and holes
    endcase
  end

  // Write channel, one request in flight until B is taken
  always_ff @(posedge sys_clk) begin
    if (!sys_rst_n) begin
      awready  <= 1'b0;
      wready   <= 1'b0;
      bvalid   <= 1'b0;
      tx_start <= 1'b0;
      divisor  <= DIV_WIDTH'(RESET_DIVISOR);
    end else begin
      awready  <= awvalid && wvalid && !bvalid && !awready;
      wready   <= awvalid && wvalid && !bvalid && !awready;
      tx_start <= tx_go;
      if (wr_hs) bvalid <= 1'b1;
      else if (bready) bvalid <= 1'b0;
      if (wr_ctrl) begin
        // Receiver needs a midpoint, so keep at least two
        divisor <= (wdata_div < DIV_WIDTH'(2)) ? DIV_WIDTH'(2) : wdata_div;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (wr_hs) bresp <= wr_resp;
    if (tx_go) tx_data <= wdata[7:0];
  end

  // Read channel
  always_ff @(posedge sys_clk) begin
    if (!sys_rst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= arvalid && !rvalid && !arready;
      if (rd_hs) rvalid <= 1'b1;
      else if (rready) rvalid <= 1'b0;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rd_hs) begin
      rdata <= rd_data;  // Held until the next accepted read
      rresp <= rd_resp;
    end
  end

  // Sticky receive status, a new event wins over a clear on the same cycle
  always_ff @(posedge sys_clk) begin
    if (!sys_rst_n) begin
      rx_valid     <= 1'b0;
      rx_overrun   <= 1'b0;
      rx_frame_err <= 1'b0;
    end else begin
      if (rd_rxdata) rx_valid <= 1'b0;
      if (rd_status) begin
        rx_overrun   <= 1'b0;
        rx_frame_err <= 1'b0;
      end
      if (rx_done) begin
        rx_valid <= 1'b1;
        if (rx_valid && !rd_rxdata) rx_overrun <= 1'b1;  // Unread byte lost
        if (frame_err) rx_frame_err <= 1'b1;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rx_done) rx_data <= rx_byte;
  end

endmodule

`default_nettype wire

/* hdl/uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_top #(
  parameter int DIV_WIDTH     = 16,
  parameter int RESET_DIVISOR = 16
) (
  input  logic                sys_clk,
  input  logic                sys_rst_n,
  input  logic [3:0]          awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  logic [31:0]         wdata,
  input  logic                wvalid,
  output logic                wready,
  output uart_pkg::axi_resp_e bresp,
  output logic                bvalid,
  input  logic                bready,
  input  logic [3:0]          araddr,
  input  logic                arvalid,
  output logic                arready,
  output logic [31:0]         rdata,
  output uart_pkg::axi_resp_e rresp,
  output logic                rvalid,
  input  logic                rready,
  input  logic                rx,
  output logic                tx
);

  logic [DIV_WIDTH-1:0] divisor;
  logic [7:0]           tx_data;
  logic                 tx_start;
  logic                 tx_busy;
  logic [7:0]           rx_byte;
  logic                 rx_done;
  logic                 frame_err;

  uart_regs #(
    .DIV_WIDTH     (DIV_WIDTH),
    .RESET_DIVISOR (RESET_DIVISOR)
  ) i_regs (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .divisor   (divisor),
    .tx_data   (tx_data),
    .tx_start  (tx_start),
    .tx_busy   (tx_busy),
    .rx_byte   (rx_byte),
    .rx_done   (rx_done),
    .frame_err (frame_err)
  );

  uart_rx #(
    .DIV_WIDTH (DIV_WIDTH)
  ) i_rx (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .rx        (rx),
    .divisor   (divisor),
    .rx_byte   (rx_byte),
    .rx_done   (rx_done),
    .frame_err (frame_err)
  );

  uart_tx #(
    .DIV_WIDTH (DIV_WIDTH)
  ) i_tx (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .divisor   (divisor),
    .tx_data   (tx_data),
    .tx_start  (tx_start),
    .tx        (tx),
    .tx_busy   (tx_busy)
  );

endmodule

`default_nettype wire

/* tests/uart_props.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_props (
  input logic        sys_clk,
  input logic        sys_rst_n,
  input logic        awvalid,
  input logic        awready,
  input logic        bvalid,
  input logic        bready,
  input logic        rvalid,
  input logic        rready,
  input logic [31:0] rdata,
  input logic        tx,
  input logic        tx_busy
);

  int fail_cnt = 0;  // Failed assertions so far

  aw_ready_needs_valid: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    awready |-> awvalid)
    else begin
      $error("awready high without awvalid");
      fail_cnt++;
    end

  // Write response holds until the master takes it
  b_valid_held: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    bvalid && !bready |=> bvalid)
    else begin
      $error("bvalid dropped before bready");
      fail_cnt++;
    end

  r_data_stable: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
      $error("rdata or rvalid changed while the read was stalled");
      fail_cnt++;
    end

  tx_idle_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    !tx_busy |-> tx)  // Line idles high between frames
    else begin
      $error("tx low while the transmitter is idle");
      fail_cnt++;
    end

endmodule

`default_nettype wire

/* tests/tb_uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_top;

  localparam int DIV_WIDTH = 16;
  localparam int TIMEOUT   = 5000;  // Cycles or polls for any single wait

  logic                sys_clk;
  logic                sys_rst_n;
  logic [3:0]          awaddr;
  logic                awvalid;
  logic                awready;
  logic [31:0]         wdata;
  logic                wvalid;
  logic                wready;
  uart_pkg::axi_resp_e bresp;
  logic                bvalid;
  logic                bready;
  logic [3:0]          araddr;
  logic                arvalid;
  logic                arready;
  logic [31:0]         rdata;
  uart_pkg::axi_resp_e rresp;
  logic                rvalid;
  logic                rready;
  logic                rx;
  logic                tx;
  integer              seed;
  int unsigned         div;  // Divisor the DUT should be using now

  uart_top #(
    .DIV_WIDTH     (DIV_WIDTH),
    .RESET_DIVISOR (16)
  ) i_dut (.*);

  bind uart_top uart_props i_props (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .awvalid   (awvalid),
    .awready   (awready),
    .bvalid    (bvalid),
    .bready    (bready),
    .rvalid    (rvalid),
    .rready    (rready),
    .rdata     (rdata),
    .tx        (tx),
    .tx_busy   (tx_busy)
  );

  initial begin
    sys_clk = 1'b0;
    forever #50 sys_clk = ~sys_clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_data(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) abort_run($sformatf("FAIL %s expected 0x%02h actual 0x%02h", name, exp, act));
  endtask

  task automatic check_resp(input string name, input uart_pkg::axi_resp_e exp,
                            input uart_pkg::axi_resp_e act);
    if (act !== exp) abort_run($sformatf("FAIL %s expected %s actual %s", name, exp.name(),
                                         act.name()));
  endtask

  task automatic check_status(input string name, input logic [3:0] exp, input logic [3:0] act);
    if (act !== exp) abort_run($sformatf("FAIL %s expected %04b actual %04b", name, exp, act));
  endtask

  task automatic check_divisor(input string name, input logic [DIV_WIDTH-1:0] exp,
                               input logic [DIV_WIDTH-1:0] act);
    if (act !== exp) abort_run($sformatf("FAIL %s expected %0d actual %0d", name, exp, act));
  endtask

  // Divisor writes below two are stored as two
  function automatic logic [DIV_WIDTH-1:0] clamp_divisor(input logic [DIV_WIDTH-1:0] value);
    return (value < 2) ? DIV_WIDTH'(2) : value;
  endfunction

  task automatic next_cycle();
    @(posedge sys_clk);
    #1;
  endtask

  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data, input int stall,
                           output uart_pkg::axi_resp_e resp);
    int n;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    n = 0;
    while (!(awready && wready)) begin
      next_cycle();
      n++;
      if (n > TIMEOUT) abort_run("Write address and data were never accepted");
    end
    next_cycle();  // Handshake edge
    awvalid = 1'b0;
    wvalid  = 1'b0;
    n = 0;
    while (!bvalid) begin
      next_cycle();
      n++;
      if (n > TIMEOUT) abort_run("Write response never arrived");
    end
    repeat (stall) next_cycle();  // bready held low
    resp   = bresp;
    bready = 1'b1;
    next_cycle();
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] addr, input int stall, output logic [31:0] data,
                          output uart_pkg::axi_resp_e resp);
    int n;
    araddr  = addr;
    arvalid = 1'b1;
    n = 0;
    while (!arready) begin
      next_cycle();
      n++;
      if (n > TIMEOUT) abort_run("Read address was never accepted");
    end
    next_cycle();
    arvalid = 1'b0;
    n = 0;
    while (!rvalid) begin
      next_cycle();
      n++;
      if (n > TIMEOUT) abort_run("Read data never arrived");
    end
    repeat (stall) next_cycle();  // rready held low
    data   = rdata;
    resp   = rresp;
    rready = 1'b1;
    next_cycle();
    rready = 1'b0;
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
    uart_pkg::axi_resp_e resp;
    axi_write(addr, data, 0, resp);
    check_resp("write_okay", uart_pkg::RESP_OKAY, resp);
  endtask

  task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
    uart_pkg::axi_resp_e resp;
    axi_read(addr, 0, data, resp);
    check_resp("read_okay", uart_pkg::RESP_OKAY, resp);
  endtask

  task automatic set_divisor(input logic [DIV_WIDTH-1:0] value);
    write_reg(uart_pkg::ADDR_CTRL, 32'(value));
    div = clamp_divisor(value);
  endtask

  // Poll STATUS until any bit in mask reaches level
  task automatic wait_status(input logic [3:0] mask, input logic level, input string what,
                             output logic [3:0] status);
    logic [31:0] data;
    int n;
    n = 0;
    do begin
      read_reg(uart_pkg::ADDR_STATUS, data);
      status = data[3:0];
      n++;
      if (n > TIMEOUT) abort_run({"Timed out waiting for ", what});
    end while ((|(status & mask)) !== level);
  endtask

  task automatic serial_send(input logic [7:0] data, input logic stop);
    logic [9:0] frame;
    int i;
    frame = {stop, data, 1'b0};
    for (i = 0; i < 10; i++) begin
      rx = frame[i];
      repeat (div) next_cycle();
    end
    rx = 1'b1;
  endtask

  task automatic serial_capture(output logic [7:0] data, output logic stop);
    int n;
    int i;
    n = 0;
    while (tx !== 1'b0) begin
      next_cycle();
      n++;
      if (n > TIMEOUT) abort_run("No start bit appeared on tx");
    end
    repeat (div / 2) next_cycle();
    if (tx !== 1'b0) abort_run("Start bit on tx did not last to mid-bit");
    for (i = 0; i < 8; i++) begin
      repeat (div) next_cycle();
      data[i] = tx;
    end
    repeat (div) next_cycle();
    stop = tx;
  endtask

  initial begin
    logic [31:0]          data;
    uart_pkg::axi_resp_e  resp;
    logic [7:0]           sent;
    logic [7:0]           second;
    logic [7:0]           got;
    logic                 stop;
    logic [DIV_WIDTH-1:0] value;
    logic [3:0]           status;
    logic [3:0]           addr;
    int                   k;
    seed      = 94447;
    div       = 16;
    sys_rst_n = 1'b0;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    rx        = 1'b1;
    repeat (10) @(posedge sys_clk);
    #1;
    sys_rst_n = 1'b1;

    // Reset values and divisor readback
    read_reg(uart_pkg::ADDR_CTRL, data);
    check_divisor("reset_ctrl", 16, data[DIV_WIDTH-1:0]);
    read_reg(uart_pkg::ADDR_STATUS, data);
    check_status("reset_status", 4'b0000, data[3:0]);
    for (k = 0; k < 12; k++) begin
      value = (k % 3 == 0) ? DIV_WIDTH'({$random(seed)} % 3) : DIV_WIDTH'($random(seed));
      set_divisor(value);
      read_reg(uart_pkg::ADDR_CTRL, data);
      check_divisor("ctrl_readback", clamp_divisor(value), data[DIV_WIDTH-1:0]);
    end

    // Illegal writes change nothing, bready stalled on each
    axi_write(uart_pkg::ADDR_STATUS, $random(seed), 1 + {$random(seed)} % 7, resp);
    check_resp("write_status", uart_pkg::RESP_SLVERR, resp);
    axi_write(uart_pkg::ADDR_RXDATA, $random(seed), 1 + {$random(seed)} % 7, resp);
    check_resp("write_rxdata", uart_pkg::RESP_SLVERR, resp);
    addr = 4'($random(seed)) | 4'h1;  // Odd addresses are never mapped
    axi_write(addr, $random(seed), 1 + {$random(seed)} % 7, resp);
    check_resp("write_unmapped", uart_pkg::RESP_SLVERR, resp);
    read_reg(uart_pkg::ADDR_CTRL, data);
    check_divisor("ctrl_kept", DIV_WIDTH'(div), data[DIV_WIDTH-1:0]);
    read_reg(uart_pkg::ADDR_STATUS, data);
    check_status("status_kept", 4'b0000, data[3:0]);
    axi_read(uart_pkg::ADDR_TXDATA, 0, data, resp);
    check_resp("read_txdata", uart_pkg::RESP_SLVERR, resp);
    check_data("read_txdata_zero", 8'h00, data[7:0]);

    // Transmit
    set_divisor(DIV_WIDTH'(4 + {$random(seed)} % 13));
    for (k = 0; k < 20; k++) begin
      sent = $random(seed);
      write_reg(uart_pkg::ADDR_TXDATA, {24'd0, sent});
      serial_capture(got, stop);
      check_data("tx_byte", sent, got);
      if (stop !== 1'b1) abort_run("Stop bit on tx was low");
      wait_status(4'b0001, 1'b0, "tx_busy to clear", status);
      check_status("tx_done", 4'b0000, status);
    end

    // Receive at random divisors
    for (k = 0; k < 20; k++) begin
      set_divisor(DIV_WIDTH'(4 + {$random(seed)} % 32));
      sent = $random(seed);
      serial_send(sent, 1'b1);
      wait_status(4'b0010, 1'b1, "rx_valid", status);
      check_status("rx_status", 4'b0010, status);
      read_reg(uart_pkg::ADDR_RXDATA, data);
      check_data("rx_byte", sent, data[7:0]);
      read_reg(uart_pkg::ADDR_STATUS, data);
      check_status("rx_cleared", 4'b0000, data[3:0]);
    end

    // The second byte overwrites the first and sets overrun
    set_divisor(DIV_WIDTH'(16));
    sent   = $random(seed);
    second = $random(seed);
    serial_send(sent, 1'b1);
    serial_send(second, 1'b1);
    wait_status(4'b0100, 1'b1, "rx_overrun", status);
    check_status("overrun_status", 4'b0110, status);
    read_reg(uart_pkg::ADDR_RXDATA, data);
    check_data("overrun_byte", second, data[7:0]);
    read_reg(uart_pkg::ADDR_STATUS, data);
    check_status("overrun_cleared", 4'b0000, data[3:0]);

    // Framing error from a low stop bit
    sent = $random(seed);
    serial_send(sent, 1'b0);
    wait_status(4'b0010, 1'b1, "rx_valid after bad stop bit", status);
    check_status("frame_err_status", 4'b1010, status);
    read_reg(uart_pkg::ADDR_RXDATA, data);
    check_data("frame_err_byte", sent, data[7:0]);
    read_reg(uart_pkg::ADDR_STATUS, data);
    check_status("frame_err_cleared", 4'b0000, data[3:0]);

    // TXDATA write during a frame is dropped
    set_divisor(DIV_WIDTH'(8));
    sent   = $random(seed);
    second = $random(seed);
    write_reg(uart_pkg::ADDR_TXDATA, {24'd0, sent});
    fork
      serial_capture(got, stop);
      begin
        repeat (2 * div) next_cycle();
        axi_write(uart_pkg::ADDR_TXDATA, {24'd0, second}, 0, resp);
      end
    join
    check_resp("busy_write", uart_pkg::RESP_OKAY, resp);
    check_data("busy_first", sent, got);
    if (stop !== 1'b1) abort_run("Stop bit on tx was low");
    wait_status(4'b0001, 1'b0, "tx_busy to clear", status);
    for (k = 0; k < 12 * div; k++) begin
      next_cycle();
      if (tx !== 1'b1) abort_run("The dropped byte was sent on tx");
    end

    // Reads stalled by rready
    for (k = 0; k < 8; k++) begin
      value = DIV_WIDTH'($random(seed));
      set_divisor(value);
      axi_read(uart_pkg::ADDR_CTRL, {$random(seed)} % 8, data, resp);
      check_resp("stalled_read_resp", uart_pkg::RESP_OKAY, resp);
      check_divisor("stalled_read", clamp_divisor(value), data[DIV_WIDTH-1:0]);
    end

    if (i_dut.i_props.fail_cnt == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      abort_run("A concurrent assertion failed during the run");
    end
  end

endmodule

`default_nettype wire

/* uart_top.f */
hdl/uart_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/uart_regs.sv
hdl/uart_top.sv
tests/uart_props.sv
tests/tb_uart_top.sv
